//--- include/axi_mem_params.svh
`ifndef AXI_MEM_PARAMS_SVH
`define AXI_MEM_PARAMS_SVH

// memory window
// word storage starts here and must be aligned to its own size
`define AXI_MEM_BASE 32'h8000_0000

// word index bits, 16 gives 64K words (256 KB)
`define AXI_MEM_AW 16

// console device
`define AXI_CON_DATA_ADDR 32'ha000_03f8   // write byte 0 to emit it
`define AXI_CON_COUNT_ADDR 32'ha000_03fc  // read bytes emitted since reset

`endif

//--- source/axi_mem_pkg.sv
`default_nettype none

`include "axi_mem_params.svh"

package axi_mem_pkg;

  localparam logic [31:0] MEM_BASE = `AXI_MEM_BASE;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_FETCH,  // address decoded, memory index presented
    RD_BEAT    // beat on r until r_ready
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_ADDR,
    WR_DATA,
    WR_COMMIT,  // memory or console write happens here
    WR_RESP
  } wr_state_e;

  typedef enum logic [1:0] {
    REG_MEM,
    REG_CON_DATA,
    REG_CON_COUNT,
    REG_NONE
  } region_e;

  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;  // beats minus one
  } axi_ar_t;

  typedef struct packed {
    logic [31:0] data;
    axi_resp_e   resp;
    logic        last;
  } axi_r_t;

  typedef struct packed {
    logic [31:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
  } axi_w_t;

  typedef struct packed {
    axi_resp_e resp;
  } axi_b_t;

  typedef struct packed {
    logic                   en;
    logic [`AXI_MEM_AW-1:0] idx;
    logic [31:0]            data;
    logic [3:0]             strb;
  } mem_wr_t;

  // shared by both engines
  function automatic region_e decode_region(input logic [31:0] addr);
    region_e region;
    if (addr[31:`AXI_MEM_AW+2] == MEM_BASE[31:`AXI_MEM_AW+2]) begin
      region = REG_MEM;
    end else if (addr == `AXI_CON_DATA_ADDR) begin
      region = REG_CON_DATA;
    end else if (addr == `AXI_CON_COUNT_ADDR) begin
      region = REG_CON_COUNT;
    end else begin
      region = REG_NONE;
    end
    return region;
  endfunction

endpackage

`default_nettype wire

//--- source/mem_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_params.svh"

module mem_array (
  input  logic                   clk,
  input  logic [`AXI_MEM_AW-1:0] rd_idx,
  output logic [31:0]            rd_data,
  input  axi_mem_pkg::mem_wr_t   wr
);

  logic [31:0] mem [0:(1 << `AXI_MEM_AW)-1];  // contents not reset

  // byte-strobed write port
  always_ff @(posedge clk) begin
    if (wr.en) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (wr.strb[lane]) begin
          mem[wr.idx][8*lane +: 8] <= wr.data[8*lane +: 8];
        end
      end
    end
  end

  // same-word read and write in one cycle sees old data
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_idx];  // registered every cycle
  end

endmodule

`default_nettype wire

//--- source/axi_read_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_params.svh"

module axi_read_engine (
  input  logic                   clk,
  input  logic                   rst,
  input  axi_mem_pkg::axi_ar_t   ar,
  input  logic                   ar_valid,
  output logic                   ar_ready,
  output axi_mem_pkg::axi_r_t    r,
  output logic                   r_valid,
  input  logic                   r_ready,
  output logic [`AXI_MEM_AW-1:0] mem_idx,
  input  logic [31:0]            mem_data,
  input  logic [31:0]            con_count
);

  axi_mem_pkg::rd_state_e state;
  axi_mem_pkg::rd_state_e state_next;
  axi_mem_pkg::region_e   cur_region;  // region of the beat in flight
  logic [31:0]            cur_addr;
  logic [7:0]             remaining;   // beats left after this one

  assign ar_ready = (state == axi_mem_pkg::RD_IDLE);
  assign r_valid  = (state == axi_mem_pkg::RD_BEAT);
  assign mem_idx  = cur_addr[`AXI_MEM_AW+1:2];  // held through RD_BEAT

  always_comb begin
    state_next = state;
    case (state)
      axi_mem_pkg::RD_IDLE: begin
        if (ar_valid) begin
          state_next = axi_mem_pkg::RD_FETCH;
        end
      end
      axi_mem_pkg::RD_FETCH: begin
        state_next = axi_mem_pkg::RD_BEAT;  // memory read takes this cycle
      end
      axi_mem_pkg::RD_BEAT: begin
        if (r_ready) begin
          state_next = r.last ? axi_mem_pkg::RD_IDLE : axi_mem_pkg::RD_FETCH;
        end
      end
      default: begin
        state_next = axi_mem_pkg::RD_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= axi_mem_pkg::RD_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // burst address and count
  always_ff @(posedge clk) begin
    if (ar_ready && ar_valid) begin
      cur_addr  <= ar.addr;
      remaining <= ar.len;
    end else if (r_valid && r_ready && !r.last) begin
      cur_addr  <= cur_addr + 32'd4;  // INCR only
      remaining <= remaining - 8'd1;
    end
    if (state == axi_mem_pkg::RD_FETCH) begin
      cur_region <= axi_mem_pkg::decode_region(cur_addr);
    end
  end

  // beat payload from the decoded region
  always_comb begin
    r.last = (remaining == 8'd0);
    case (cur_region)
      axi_mem_pkg::REG_MEM: begin
        r.data = mem_data;
        r.resp = axi_mem_pkg::OKAY;
      end
      axi_mem_pkg::REG_CON_COUNT: begin
        r.data = con_count;
        r.resp = axi_mem_pkg::OKAY;
      end
      default: begin
        r.data = 32'd0;  // console data is write only
        r.resp = axi_mem_pkg::SLVERR;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/axi_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_params.svh"

module axi_write_engine (
  input  logic                 clk,
  input  logic                 rst,
  input  axi_mem_pkg::axi_aw_t aw,
  input  logic                 aw_valid,
  output logic                 aw_ready,
  input  axi_mem_pkg::axi_w_t  w,
  input  logic                 w_valid,
  output logic                 w_ready,
  output axi_mem_pkg::axi_b_t  b,
  output logic                 b_valid,
  input  logic                 b_ready,
  output axi_mem_pkg::mem_wr_t mem_wr,
  output logic                 con_wr,
  output logic [7:0]           con_wr_byte
);

  axi_mem_pkg::wr_state_e state;
  axi_mem_pkg::wr_state_e state_next;
  axi_mem_pkg::region_e   commit_region;
  axi_mem_pkg::axi_resp_e resp_q;
  axi_mem_pkg::axi_w_t    w_q;
  logic [31:0]            aw_addr_q;
  logic                   commit;

  assign aw_ready = (state == axi_mem_pkg::WR_ADDR);
  assign w_ready  = (state == axi_mem_pkg::WR_DATA);
  assign b_valid  = (state == axi_mem_pkg::WR_RESP);
  assign commit   = (state == axi_mem_pkg::WR_COMMIT);
  assign b.resp   = resp_q;

  assign commit_region = axi_mem_pkg::decode_region(aw_addr_q);

  always_comb begin
    state_next = state;
    case (state)
      axi_mem_pkg::WR_ADDR: begin
        if (aw_valid) begin
          state_next = axi_mem_pkg::WR_DATA;
        end
      end
      axi_mem_pkg::WR_DATA: begin
        if (w_valid) begin
          state_next = axi_mem_pkg::WR_COMMIT;
        end
      end
      axi_mem_pkg::WR_COMMIT: begin
        state_next = axi_mem_pkg::WR_RESP;  // always one cycle
      end
      default: begin
        if (b_ready) begin
          state_next = axi_mem_pkg::WR_ADDR;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= axi_mem_pkg::WR_ADDR;
    end else begin
      state <= state_next;
    end
  end

  // request payload and response code
  always_ff @(posedge clk) begin
    if (aw_ready && aw_valid) begin
      aw_addr_q <= aw.addr;
    end
    if (w_ready && w_valid) begin
      w_q <= w;
    end
    if (commit) begin
      if (commit_region == axi_mem_pkg::REG_MEM ||
          commit_region == axi_mem_pkg::REG_CON_DATA) begin
        resp_q <= axi_mem_pkg::OKAY;
      end else begin
        resp_q <= axi_mem_pkg::SLVERR;  // count is read only
      end
    end
  end

  // memory write lands on the edge that leaves WR_COMMIT
  assign mem_wr.en   = commit && (commit_region == axi_mem_pkg::REG_MEM);
  assign mem_wr.idx  = aw_addr_q[`AXI_MEM_AW+1:2];
  assign mem_wr.data = w_q.data;
  assign mem_wr.strb = w_q.strb;

  // console takes byte 0 only when its lane is strobed
  assign con_wr      = commit && (commit_region == axi_mem_pkg::REG_CON_DATA) && w_q.strb[0];
  assign con_wr_byte = w_q.data[7:0];

endmodule

`default_nettype wire

//--- source/console_regs.sv
`timescale 1ns/1ps
`default_nettype none

module console_regs (
  input  logic        clk,
  input  logic        rst,
  input  logic        con_wr,
  input  logic [7:0]  con_wr_byte,
  output logic [7:0]  con_data,
  output logic        con_valid,
  output logic [31:0] con_count
);

  // one pulse per accepted byte
  always_ff @(posedge clk) begin
    if (rst) begin
      con_valid <= 1'b0;
    end else begin
      con_valid <= con_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (con_wr) begin
      con_data <= con_wr_byte;  // holds until the next byte
    end
  end

  // emitted-byte counter, served by the read engine
  always_ff @(posedge clk) begin
    if (rst) begin
      con_count <= 32'd0;
    end else if (con_wr) begin
      con_count <= con_count + 32'd1;
    end
  end

endmodule

`default_nettype wire

//--- source/axi_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_params.svh"

module axi_mem_top (
  input  logic                 clk,
  input  logic                 rst,
  input  axi_mem_pkg::axi_ar_t ar,
  input  logic                 ar_valid,
  output logic                 ar_ready,
  output axi_mem_pkg::axi_r_t  r,
  output logic                 r_valid,
  input  logic                 r_ready,
  input  axi_mem_pkg::axi_aw_t aw,
  input  logic                 aw_valid,
  output logic                 aw_ready,
  input  axi_mem_pkg::axi_w_t  w,
  input  logic                 w_valid,
  output logic                 w_ready,
  output axi_mem_pkg::axi_b_t  b,
  output logic                 b_valid,
  input  logic                 b_ready,
  output logic [7:0]           con_data,
  output logic                 con_valid
);

  logic [`AXI_MEM_AW-1:0] mem_idx;
  logic [31:0]            mem_rd_data;
  axi_mem_pkg::mem_wr_t   mem_wr;
  logic                   con_wr;
  logic [7:0]             con_wr_byte;
  logic [31:0]            con_count;

  mem_array mem_array_inst (
    .clk     (clk),
    .rd_idx  (mem_idx),
    .rd_data (mem_rd_data),
    .wr      (mem_wr)
  );

  axi_read_engine axi_read_engine_inst (
    .clk       (clk),
    .rst       (rst),
    .ar        (ar),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .r         (r),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .mem_idx   (mem_idx),
    .mem_data  (mem_rd_data),
    .con_count (con_count)
  );

  axi_write_engine axi_write_engine_inst (
    .clk         (clk),
    .rst         (rst),
    .aw          (aw),
    .aw_valid    (aw_valid),
    .aw_ready    (aw_ready),
    .w           (w),
    .w_valid     (w_valid),
    .w_ready     (w_ready),
    .b           (b),
    .b_valid     (b_valid),
    .b_ready     (b_ready),
    .mem_wr      (mem_wr),
    .con_wr      (con_wr),
    .con_wr_byte (con_wr_byte)
  );

  console_regs console_regs_inst (
    .clk         (clk),
    .rst         (rst),
    .con_wr      (con_wr),
    .con_wr_byte (con_wr_byte),
    .con_data    (con_data),
    .con_valid   (con_valid),
    .con_count   (con_count)
  );

endmodule

`default_nettype wire

//--- bench/axi_mem_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_asserts (
  input logic                clk,
  input logic                rst,
  input axi_mem_pkg::axi_r_t r,
  input logic                r_valid,
  input logic                r_ready,
  input logic                ar_ready,
  input logic                b_valid,
  input logic                b_ready,
  input logic                con_valid
);

  int unsigned fail_count = 0;  // summed into the testbench error count

  r_hold: assert property (@(posedge clk) disable iff (rst)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else begin
      $error("r beat changed while r_ready was low");
      fail_count++;
    end

  b_hold: assert property (@(posedge clk) disable iff (rst)
    b_valid && !b_ready |=> b_valid)
    else begin
      $error("b_valid dropped before b_ready");
      fail_count++;
    end

  // no new request while a beat is out
  ar_busy: assert property (@(posedge clk) disable iff (rst)
    r_valid |-> !ar_ready)
    else begin
      $error("ar_ready high while r_valid is high");
      fail_count++;
    end

  con_pulse: assert property (@(posedge clk) disable iff (rst)
    con_valid |=> !con_valid)
    else begin
      $error("con_valid lasted two cycles");
      fail_count++;
    end

endmodule

bind axi_mem_top axi_mem_asserts axi_mem_asserts_inst (.*);

`default_nettype wire

//--- bench/axi_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_tb;

  localparam int MAX_OPS = 64;

  logic                 clk;
  logic                 rst;
  axi_mem_pkg::axi_ar_t ar;
  logic                 ar_valid;
  logic                 ar_ready;
  axi_mem_pkg::axi_r_t  r;
  logic                 r_valid;
  logic                 r_ready;
  axi_mem_pkg::axi_aw_t aw;
  logic                 aw_valid;
  logic                 aw_ready;
  axi_mem_pkg::axi_w_t  w;
  logic                 w_valid;
  logic                 w_ready;
  axi_mem_pkg::axi_b_t  b;
  logic                 b_valid;
  logic                 b_ready;
  logic [7:0]           con_data;
  logic                 con_valid;

  logic [7:0]  op_code [MAX_OPS];
  logic [31:0] op_addr [MAX_OPS];
  logic [31:0] op_arg [MAX_OPS];   // strobe or burst length
  logic [31:0] op_wdata [MAX_OPS];
  logic [31:0] op_err [MAX_OPS];   // per-beat SLVERR mask
  logic [31:0] op_exp [MAX_OPS][4];
  int          n_ops = 0;
  int          errors = 0;
  int          cycle = 0;
  integer      seed;
  logic        loaded = 1'b0;
  logic [7:0]  con_bytes [$];
  int          con_cycles [$];

  axi_mem_top axi_mem_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // console monitor
  always @(negedge clk) begin
    if (!rst && con_valid) begin
      con_bytes.push_back(con_data);
      con_cycles.push_back(cycle);
    end
  end

  task automatic load_patterns();
    int          fd;
    int          cnt;
    string       line;
    logic [7:0]  op;
    logic [31:0] a, g, wd, e, d0, d1, d2, d3;
    fd = $fopen("bench/axi_mem_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") continue;  // comments, blanks
        cnt = $sscanf(line, "%c %h %h %h %h %h %h %h %h", op, a, g, wd, e, d0, d1, d2, d3);
        if (cnt != 9 || n_ops == MAX_OPS) begin
          $display("pattern line %0d is malformed or past the table size", n_ops);
          errors++;
        end else begin
          op_code[n_ops]  = op;
          op_addr[n_ops]  = a;
          op_arg[n_ops]   = g;
          op_wdata[n_ops] = wd;
          op_err[n_ops]   = e;
          op_exp[n_ops]   = '{d0, d1, d2, d3};
          n_ops++;
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
  endtask

  task automatic drive_edge();
    @(posedge clk);
    #1;
  endtask

  task automatic compare_r(input axi_mem_pkg::axi_r_t exp, input axi_mem_pkg::axi_r_t act,
                           input int op, input int beat);
    if (act !== exp) begin
      $display("[FAIL] r op %0d beat %0d: expected data %h resp %h last %h, got %h %h %h",
               op, beat, exp.data, exp.resp, exp.last, act.data, act.resp, act.last);
      errors++;
    end
  endtask

  task automatic compare_b(input axi_mem_pkg::axi_b_t exp, input axi_mem_pkg::axi_b_t act,
                           input int op);
    if (act !== exp) begin
      $display("[FAIL] b.resp op %0d: expected %h, got %h", op, exp.resp, act.resp);
      errors++;
    end
  endtask

  task automatic compare_con(input logic [7:0] exp, input logic [7:0] act, input int op);
    if (act !== exp) begin
      $display("[FAIL] con_data op %0d: expected %h, got %h", op, exp, act);
      errors++;
    end
  endtask

  task automatic do_write(input int i);
    axi_mem_pkg::axi_b_t exp_b;
    int                  w_cycle;
    int                  n_before;
    n_before = con_bytes.size();
    aw.addr  = op_addr[i];
    aw_valid = 1'b1;
    do @(negedge clk); while (!aw_ready);
    drive_edge();
    aw_valid = 1'b0;
    w.data   = op_wdata[i];
    w.strb   = op_arg[i][3:0];
    w_valid  = 1'b1;
    do @(negedge clk); while (!w_ready);
    w_cycle = cycle;
    drive_edge();
    w_valid = 1'b0;
    b_ready = ($random(seed) & 1) != 0;  // sometimes hold the response a cycle
    do @(negedge clk); while (!b_valid);
    if (cycle != w_cycle + 2) begin
      $display("op %0d: b_valid rose %0d cycles after the W handshake, not 2", i, cycle - w_cycle);
      errors++;
    end
    exp_b.resp = op_err[i][0] ? axi_mem_pkg::SLVERR : axi_mem_pkg::OKAY;
    compare_b(exp_b, b, i);
    if (!b_ready) begin
      drive_edge();
      b_ready = 1'b1;
    end
    drive_edge();
    b_ready = 1'b0;
    if (con_bytes.size() != n_before + op_exp[i][0]) begin
      $display("op %0d: console emitted %0d bytes, expected %0d", i,
               con_bytes.size() - n_before, op_exp[i][0]);
      errors++;
    end else if (op_exp[i][0] != 0) begin
      compare_con(op_exp[i][1][7:0], con_bytes[n_before], i);
      if (con_cycles[n_before] != w_cycle + 2) begin
        $display("op %0d: con_valid did not pulse 2 cycles after the W handshake", i);
        errors++;
      end
    end
  endtask

  task automatic do_read(input int i);
    axi_mem_pkg::axi_r_t exp_r;
    int                  beat;
    int                  hs_cycle;
    int                  len;
    logic                seen;
    len      = op_arg[i];
    ar.addr  = op_addr[i];
    ar.len   = op_arg[i][7:0];
    ar_valid = 1'b1;
    do @(negedge clk); while (!ar_ready);
    hs_cycle = cycle;
    drive_edge();
    ar_valid = 1'b0;
    beat     = 0;
    seen     = 1'b0;
    while (beat <= len) begin
      r_ready = ($random(seed) & 3) != 0;  // stall about one cycle in four
      @(negedge clk);
      if (r_valid && !seen) begin
        seen = 1'b1;
        if (cycle != hs_cycle + 2) begin
          $display("op %0d beat %0d: r_valid rose %0d cycles after the handshake, not 2",
                   i, beat, cycle - hs_cycle);
          errors++;
        end
      end
      if (r_valid && r_ready) begin
        exp_r.data = op_exp[i][beat];
        exp_r.resp = op_err[i][beat] ? axi_mem_pkg::SLVERR : axi_mem_pkg::OKAY;
        exp_r.last = (beat == len);
        compare_r(exp_r, r, i, beat);
        hs_cycle = cycle;
        seen     = 1'b0;
        beat++;
      end
      drive_edge();
    end
    r_ready = 1'b0;
  endtask

  task automatic finish_run();
    int unsigned asserts;
    asserts = axi_mem_top_inst.axi_mem_asserts_inst.fail_count;
    $display("errors: %0d check failures, %0d assertion failures", errors, asserts);
    if (errors == 0 && asserts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  // watchdog
  initial begin
    wait (loaded);
    repeat (n_ops * 64 + 100) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", n_ops * 64 + 100);
    errors++;
    finish_run();
  end

  initial begin
    seed     = 32'h5c42_7c47;
    rst      = 1'b1;
    ar       = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    load_patterns();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    if (r_valid || b_valid || w_ready || con_valid || !ar_ready || !aw_ready) begin
      $display("channel outputs are not in their idle state after reset");
      errors++;
    end
    for (int i = 0; i < n_ops; i++) begin
      drive_edge();
      if (op_code[i] == "W") begin
        do_write(i);
      end else begin
        do_read(i);
      end
    end
    repeat (4) drive_edge();
    finish_run();
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
source/axi_mem_pkg.sv
source/mem_array.sv
source/axi_read_engine.sv
source/axi_write_engine.sv
source/console_regs.sv
source/axi_mem_top.sv
bench/axi_mem_asserts.sv
bench/axi_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the AXI memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module axi_mem_tb -f verilog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# keep running past assertion errors so the testbench prints its summary
./obj_dir/Vaxi_mem_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- bench/axi_mem_patterns.txt
# op addr arg wdata err d0 d1 d2 d3, all hex
# W: arg strobe, err bit0 SLVERR, d0 console bytes expected, d1 the byte
# R: arg len, err bit i beat i SLVERR, d0..d3 expected beat data
W 80000000 f 11223344 0 0 0 0 0
R 80000000 0 0 0 11223344 0 0 0
W 80000004 f aabbccdd 0 0 0 0 0
W 80000004 3 00005566 0 0 0 0 0
R 80000004 0 0 0 aabb5566 0 0 0
W 80000004 8 77000000 0 0 0 0 0
W 80000004 4 00990000 0 0 0 0 0
R 80000004 0 0 0 77995566 0 0 0
W 80000008 f 0badf00d 0 0 0 0 0
W 8000000c f 12345678 0 0 0 0 0
R 80000000 3 0 0 11223344 77995566 0badf00d 12345678
R 80000004 2 0 0 77995566 0badf00d 12345678 0
W 8003fffc f cafebabe 0 0 0 0 0
R 8003fffc 0 0 0 cafebabe 0 0 0
W a00003f8 1 00000048 0 1 48 0 0
W a00003f8 f 00000069 0 1 69 0 0
W a00003f8 e 00000021 0 0 0 0 0
W a00003f8 1 0000000a 0 1 0a 0 0
R a00003fc 0 0 0 00000003 0 0 0
R 80000000 1 0 0 11223344 77995566 0 0
R a00003f8 0 0 1 0 0 0 0
R a00003f8 2 0 5 0 00000003 0 0
W a00003fc f 00000055 1 0 0 0 0
R a00003fc 0 0 0 00000003 0 0 0
W 90000000 f deadbeef 1 0 0 0 0
R 90000000 0 0 1 0 0 0 0
W 80040000 f deadbeef 1 0 0 0 0
R 80040000 0 0 1 0 0 0 0
R 80000000 0 0 0 11223344 0 0 0
R 7ffffffc 1 0 1 0 11223344 0 0
R 8000000c 0 0 0 12345678 0 0 0
